//--- logic/fsa_pkg.sv
package fsa_pkg;

	// row and column index width
	localparam int dim_w = 12;
	localparam int ref_w = 8;

	localparam int axil_addr_w = 5;
	localparam int axil_data_w = 32;

	// one record per column, kept across the frame
	typedef struct packed {
		logic             val;
		logic [dim_w-1:0] top;
		logic [dim_w-1:0] bot;
	} col_rec_t;

	typedef struct packed {
		logic             found;
		logic [dim_w-1:0] x;
	} edge_res_t;

	typedef struct packed {
		logic [dim_w-1:0] height;
		logic [dim_w-1:0] width;
		logic [ref_w-1:0] ref_level;
	} fsa_cfg_t;

	// register map, one 32-bit word each
	localparam logic [axil_addr_w-1:0] reg_status  = 5'h00;
	localparam logic [axil_addr_w-1:0] reg_height  = 5'h04;
	localparam logic [axil_addr_w-1:0] reg_width   = 5'h08;
	localparam logic [axil_addr_w-1:0] reg_ref     = 5'h0C;
	localparam logic [axil_addr_w-1:0] reg_left    = 5'h10;
	localparam logic [axil_addr_w-1:0] reg_right   = 5'h14;
	localparam logic [axil_addr_w-1:0] reg_col_sel = 5'h18;
	localparam logic [axil_addr_w-1:0] reg_col_rec = 5'h1C;

endpackage

//--- logic/column_store.sv
`timescale 1ns/1ps

module column_store
	import fsa_pkg::*;
(
	input  logic             clk,
	input  logic             rd_en,
	input  logic [dim_w-1:0] rd_addr,
	output col_rec_t         rd_rec,
	input  logic             wr_en,
	input  logic [dim_w-1:0] wr_addr,
	input  col_rec_t         wr_rec,
	input  logic [dim_w-1:0] host_addr,
	output col_rec_t         host_rec
);
	localparam int depth = 1 << dim_w;

	// row 0 rewrites every column, so no clearing
	col_rec_t mem [depth];

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_addr] <= wr_rec;
	end

	// pipeline port
	always_ff @(posedge clk) begin
		if (rd_en)
			rd_rec <= mem[rd_addr];
	end

	// host readback, free running
	always_ff @(posedge clk) begin
		host_rec <= mem[host_addr];
	end

endmodule

//--- logic/edge_scan.sv
`timescale 1ns/1ps

module edge_scan
	import fsa_pkg::*;
(
	input  logic             clk,
	input  logic             resetn,
	input  logic             scan_en,
	input  logic             scan_first,
	input  logic             scan_last,
	input  logic [dim_w-1:0] scan_x,
	input  col_rec_t         scan_rec,
	output edge_res_t        left,
	output edge_res_t        right
);
	logic             left_open;
	logic             prev_val;
	logic             run_cont;
	logic [dim_w-1:0] run_start;

	// column continues a dark run from the previous column
	assign run_cont = prev_val && !scan_first;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			left      <= '0;
			right     <= '0;
			left_open <= 1'b0;
			prev_val  <= 1'b0;
		end else if (scan_en) begin
			prev_val <= scan_rec.val;
			if (scan_first) begin
				left.found <= scan_rec.val;
				left.x     <= '0;
				left_open  <= scan_rec.val;
				right      <= '0;
			end else if (left_open) begin
				if (scan_rec.val)
					left.x <= scan_x;
				else
					left_open <= 1'b0;
			end
			if (scan_last) begin
				right.found <= scan_rec.val;
				if (!scan_rec.val)
					right.x <= '0;
				else if (run_cont)
					right.x <= run_start;
				else
					right.x <= scan_x;
			end
		end
	end

	// first column of the current run
	always_ff @(posedge clk) begin
		if (scan_en && scan_rec.val && !run_cont)
			run_start <= scan_x;
	end

	a_first_last: assert property (@(posedge clk) disable iff (!resetn)
		scan_en |-> !(scan_first && scan_last));

endmodule

//--- logic/fsa_core.sv
`timescale 1ns/1ps

module fsa_core
	import fsa_pkg::*;
#(
	parameter int pixel_w = 8
) (
	input  logic               clk,
	input  logic               resetn,
	input  fsa_cfg_t           cfg,
	input  logic               s_axis_tvalid,
	input  logic [pixel_w-1:0] s_axis_tdata,
	input  logic               s_axis_tuser,
	input  logic               s_axis_tlast,
	output logic               s_axis_tready,
	output logic               rd_en,
	output logic [dim_w-1:0]   rd_addr,
	input  col_rec_t           rd_rec,
	output logic               wr_en,
	output logic [dim_w-1:0]   wr_addr,
	output col_rec_t           wr_rec,
	output logic               scan_en,
	output logic               scan_first,
	output logic               scan_last,
	output logic [dim_w-1:0]   scan_x,
	output col_rec_t           scan_rec,
	output logic               sof,
	output logic               ana_done
);
	// what each pixel carries down the pipe
	typedef struct packed {
		logic             dark;
		logic             row0;
		logic             last_row;
		logic             first_col;
		logic             last_col;
		logic             eof;
		logic [dim_w-1:0] x;
		logic [dim_w-1:0] y;
	} pix_info_t;

	logic               beat;
	logic [dim_w-1:0]   next_x;
	logic [dim_w-1:0]   next_y;
	logic [dim_w-1:0]   cur_x;
	logic [dim_w-1:0]   cur_y;
	logic [pixel_w-1:0] ref_pix;
	pix_info_t          cur_info;
	pix_info_t          info_p0;
	pix_info_t          info_p1;
	pix_info_t          info_p2;
	logic               vld_p1;
	logic               vld_p2;
	col_rec_t           old_rec_p2;
	col_rec_t           base_rec;
	col_rec_t           new_rec;
	logic               eof_p3;

	// no back-pressure on the pixel stream
	assign s_axis_tready = 1'b1;
	assign beat = s_axis_tvalid && s_axis_tready;

	assign cur_x = s_axis_tuser ? '0 : next_x;
	assign cur_y = s_axis_tuser ? '0 : next_y;
	assign ref_pix = pixel_w'(cfg.ref_level);

	always_comb begin
		cur_info.dark      = s_axis_tdata < ref_pix;
		cur_info.row0      = cur_y == '0;
		cur_info.last_row  = cur_y == cfg.height - 1'b1;
		cur_info.first_col = cur_x == '0;
		cur_info.last_col  = cur_x == cfg.width - 1'b1;
		cur_info.eof       = s_axis_tlast && cur_info.last_row;
		cur_info.x         = cur_x;
		cur_info.y         = cur_y;
	end

	// position of the next beat
	always_ff @(posedge clk) begin
		if (!resetn) begin
			next_x <= '0;
			next_y <= '0;
		end else if (beat) begin
			if (s_axis_tlast) begin
				next_x <= '0;
				next_y <= cur_y + 1'b1;
			end else begin
				next_x <= cur_x + 1'b1;
				next_y <= cur_y;
			end
		end
	end

	// stage 0 issues the read, stage 1 gets it back
	always_ff @(posedge clk) begin
		if (beat)
			info_p0 <= cur_info;
		info_p1    <= info_p0;
		info_p2    <= info_p1;
		old_rec_p2 <= rd_rec;
	end

	assign rd_addr = info_p0.x;

	// row 0 starts every column from scratch
	always_comb begin
		base_rec = info_p2.row0 ? '0 : old_rec_p2;
		new_rec  = base_rec;
		if (info_p2.dark) begin
			new_rec.val = 1'b1;
			new_rec.bot = info_p2.y;
			if (!base_rec.val)
				new_rec.top = info_p2.y;
		end
	end

	always_ff @(posedge clk) begin
		wr_addr <= info_p2.x;
		wr_rec  <= new_rec;
	end

	assign scan_x   = wr_addr;
	assign scan_rec = wr_rec;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			rd_en      <= 1'b0;
			sof        <= 1'b0;
			vld_p1     <= 1'b0;
			vld_p2     <= 1'b0;
			wr_en      <= 1'b0;
			scan_en    <= 1'b0;
			scan_first <= 1'b0;
			scan_last  <= 1'b0;
			eof_p3     <= 1'b0;
			ana_done   <= 1'b0;
		end else begin
			rd_en      <= beat;
			sof        <= beat && s_axis_tuser;
			vld_p1     <= rd_en;
			vld_p2     <= vld_p1;
			wr_en      <= vld_p2;
			scan_en    <= vld_p2 && info_p2.last_row;
			scan_first <= vld_p2 && info_p2.first_col;
			scan_last  <= vld_p2 && info_p2.last_col;
			eof_p3     <= vld_p2 && info_p2.eof;
			ana_done   <= eof_p3;
		end
	end

	// a column must be written back before the next row reads it
	a_min_width: assert property (@(posedge clk) disable iff (!resetn)
		beat && s_axis_tuser |-> cfg.width >= 4);

	a_no_rw_clash: assert property (@(posedge clk) disable iff (!resetn)
		rd_en && wr_en |-> rd_addr != wr_addr);

endmodule

//--- logic/fsa_regs.sv
`timescale 1ns/1ps

module fsa_regs
	import fsa_pkg::*;
#(
	parameter int pixel_w = 8
) (
	input  logic                      clk,
	input  logic                      resetn,
	input  logic [axil_addr_w-1:0]    s_axil_awaddr,
	input  logic                      s_axil_awvalid,
	output logic                      s_axil_awready,
	input  logic [axil_data_w-1:0]    s_axil_wdata,
	input  logic [axil_data_w/8-1:0]  s_axil_wstrb,
	input  logic                      s_axil_wvalid,
	output logic                      s_axil_wready,
	output logic [1:0]                s_axil_bresp,
	output logic                      s_axil_bvalid,
	input  logic                      s_axil_bready,
	input  logic [axil_addr_w-1:0]    s_axil_araddr,
	input  logic                      s_axil_arvalid,
	output logic                      s_axil_arready,
	output logic [axil_data_w-1:0]    s_axil_rdata,
	output logic [1:0]                s_axil_rresp,
	output logic                      s_axil_rvalid,
	input  logic                      s_axil_rready,
	output fsa_cfg_t                  cfg,
	input  logic                      sof,
	input  logic                      ana_done,
	input  edge_res_t                 left,
	input  edge_res_t                 right,
	output logic [dim_w-1:0]          host_addr,
	input  col_rec_t                  host_rec,
	output logic                      frame_done
);
	logic                     aw_got;
	logic                     w_got;
	logic [axil_addr_w-1:0]   aw_addr_q;
	logic [axil_data_w-1:0]   wdata_q;
	logic [axil_data_w/8-1:0] wstrb_q;
	logic                     wr_fire;
	logic [axil_data_w-1:0]   wr_old;
	logic [axil_data_w-1:0]   wr_word;
	logic [axil_addr_w-1:0]   ar_sel;
	logic                     ar_fire;
	logic                     rec_wait;
	logic [axil_data_w-1:0]   rd_word;
	logic                     status_clr;
	logic                     done;
	edge_res_t                left_q;
	edge_res_t                right_q;

	function automatic logic [axil_addr_w-1:0] word_addr(input logic [axil_addr_w-1:0] a);
		return {a[axil_addr_w-1:2], 2'b00};
	endfunction

	function automatic logic [axil_data_w-1:0] merge_strb(input logic [axil_data_w-1:0] old,
		input logic [axil_data_w-1:0] data, input logic [axil_data_w/8-1:0] strb);
		logic [axil_data_w-1:0] res;
		for (int i = 0; i < axil_data_w / 8; i++)
			res[8*i +: 8] = strb[i] ? data[8*i +: 8] : old[8*i +: 8];
		return res;
	endfunction

	// found in bit 31, x in the low bits
	function automatic logic [axil_data_w-1:0] edge_word(input edge_res_t e);
		return {e.found, {(axil_data_w-1-dim_w){1'b0}}, e.x};
	endfunction

	assign s_axil_awready = !aw_got && !s_axil_bvalid;
	assign s_axil_wready  = !w_got && !s_axil_bvalid;
	assign s_axil_bresp   = 2'b00;
	assign s_axil_rresp   = 2'b00;
	assign wr_fire        = aw_got && w_got;

	always_comb begin
		case (aw_addr_q)
			reg_height:  wr_old = axil_data_w'(cfg.height);
			reg_width:   wr_old = axil_data_w'(cfg.width);
			reg_ref:     wr_old = axil_data_w'(cfg.ref_level);
			reg_col_sel: wr_old = axil_data_w'(host_addr);
			default:     wr_old = '0;
		endcase
		wr_word = merge_strb(wr_old, wdata_q, wstrb_q);
	end

	always_ff @(posedge clk) begin
		if (s_axil_awvalid && s_axil_awready)
			aw_addr_q <= word_addr(s_axil_awaddr);
		if (s_axil_wvalid && s_axil_wready) begin
			wdata_q <= s_axil_wdata;
			wstrb_q <= s_axil_wstrb;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			aw_got        <= 1'b0;
			w_got         <= 1'b0;
			s_axil_bvalid <= 1'b0;
			cfg           <= '0;
			host_addr     <= '0;
		end else begin
			if (s_axil_awvalid && s_axil_awready)
				aw_got <= 1'b1;
			if (s_axil_wvalid && s_axil_wready)
				w_got <= 1'b1;
			if (s_axil_bvalid && s_axil_bready)
				s_axil_bvalid <= 1'b0;
			if (wr_fire) begin
				aw_got        <= 1'b0;
				w_got         <= 1'b0;
				s_axil_bvalid <= 1'b1;
				// read-only offsets fall through
				case (aw_addr_q)
					reg_height:  cfg.height    <= wr_word[dim_w-1:0];
					reg_width:   cfg.width     <= wr_word[dim_w-1:0];
					reg_ref:     cfg.ref_level <= ref_w'(wr_word[pixel_w-1:0]);
					reg_col_sel: host_addr     <= wr_word[dim_w-1:0];
					default: ;
				endcase
			end
		end
	end

	assign ar_sel         = word_addr(s_axil_araddr);
	assign s_axil_arready = !s_axil_rvalid && !rec_wait;
	assign ar_fire        = s_axil_arvalid && s_axil_arready;
	assign status_clr     = ar_fire && ar_sel == reg_status && done;

	always_comb begin
		case (ar_sel)
			reg_status:  rd_word = axil_data_w'(done);
			reg_height:  rd_word = axil_data_w'(cfg.height);
			reg_width:   rd_word = axil_data_w'(cfg.width);
			reg_ref:     rd_word = axil_data_w'(cfg.ref_level);
			reg_left:    rd_word = edge_word(left_q);
			reg_right:   rd_word = edge_word(right_q);
			reg_col_sel: rd_word = axil_data_w'(host_addr);
			default:     rd_word = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			s_axil_rvalid <= 1'b0;
			rec_wait      <= 1'b0;
		end else begin
			if (s_axil_rvalid && s_axil_rready)
				s_axil_rvalid <= 1'b0;
			if (ar_fire) begin
				if (ar_sel == reg_col_rec)
					rec_wait <= 1'b1;
				else
					s_axil_rvalid <= 1'b1;
			end
			if (rec_wait) begin
				rec_wait      <= 1'b0;
				s_axil_rvalid <= 1'b1;
			end
		end
	end

	// column record waits one cycle for the store
	always_ff @(posedge clk) begin
		if (rec_wait)
			s_axil_rdata <= {host_rec.val, 3'b000, host_rec.top, 4'b0000, host_rec.bot};
		else if (ar_fire)
			s_axil_rdata <= rd_word;
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			done       <= 1'b0;
			frame_done <= 1'b0;
		end else begin
			frame_done <= ana_done;
			if (ana_done)
				done <= 1'b1;
			else if (sof || status_clr)
				done <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (ana_done) begin
			left_q  <= left;
			right_q <= right;
		end
	end

	a_rvalid_hold: assert property (@(posedge clk) disable iff (!resetn)
		s_axil_rvalid && !s_axil_rready |=> s_axil_rvalid && $stable(s_axil_rdata));

endmodule

//--- logic/fsa_top.sv
`timescale 1ns/1ps

module fsa_top
	import fsa_pkg::*;
#(
	parameter int pixel_w = 8
) (
	input  logic                      clk,
	input  logic                      resetn,
	input  logic                      s_axis_tvalid,
	input  logic [pixel_w-1:0]        s_axis_tdata,
	input  logic                      s_axis_tuser,
	input  logic                      s_axis_tlast,
	output logic                      s_axis_tready,
	input  logic [axil_addr_w-1:0]    s_axil_awaddr,
	input  logic                      s_axil_awvalid,
	output logic                      s_axil_awready,
	input  logic [axil_data_w-1:0]    s_axil_wdata,
	input  logic [axil_data_w/8-1:0]  s_axil_wstrb,
	input  logic                      s_axil_wvalid,
	output logic                      s_axil_wready,
	output logic [1:0]                s_axil_bresp,
	output logic                      s_axil_bvalid,
	input  logic                      s_axil_bready,
	input  logic [axil_addr_w-1:0]    s_axil_araddr,
	input  logic                      s_axil_arvalid,
	output logic                      s_axil_arready,
	output logic [axil_data_w-1:0]    s_axil_rdata,
	output logic [1:0]                s_axil_rresp,
	output logic                      s_axil_rvalid,
	input  logic                      s_axil_rready,
	output logic                      frame_done
);
	fsa_cfg_t         cfg;
	logic             rd_en;
	logic [dim_w-1:0] rd_addr;
	col_rec_t         rd_rec;
	logic             wr_en;
	logic [dim_w-1:0] wr_addr;
	col_rec_t         wr_rec;
	logic             scan_en;
	logic             scan_first;
	logic             scan_last;
	logic [dim_w-1:0] scan_x;
	col_rec_t         scan_rec;
	edge_res_t        left;
	edge_res_t        right;
	logic             sof;
	logic             ana_done;
	logic [dim_w-1:0] host_addr;
	col_rec_t         host_rec;

	// pixel pipeline
	fsa_core #(.pixel_w(pixel_w)) u_core (.*);

	column_store u_store (.*);

	edge_scan u_scan (.*);

	// host side
	fsa_regs #(.pixel_w(pixel_w)) u_regs (.*);

endmodule

//--- bench/fsa_tb.sv
`timescale 1ns/1ps

module fsa_tb
	import fsa_pkg::*;
();
	localparam int pixel_w = 8;
	localparam int n_frames = 6;

	// object rectangle x0..x1 by y0..y1 is dark on a light background
	typedef struct packed {
		int               width;
		int               height;
		logic [ref_w-1:0] ref_level;
		int               x0;
		int               x1;
		int               y0;
		int               y1;
		logic [3:0]       gap_mask;
	} frame_t;

	frame_t frames [n_frames] = '{
		'{16, 16, 8'd100, 4, 9, 2, 9, 4'h0},
		'{12, 6, 8'd128, 0, 11, 1, 5, 4'h0},
		'{20, 12, 8'd50, 3, 15, 4, 7, 4'h3},
		'{10, 8, 8'd100, 0, 6, 0, 7, 4'h1},
		'{9, 6, 8'd30, 5, 8, 2, 3, 4'h7},
		'{8, 4, 8'd16, 0, 7, 0, 3, 4'h1}
	};

	logic                     clk = 1'b0;
	logic                     resetn;
	logic                     s_axis_tvalid;
	logic [pixel_w-1:0]       s_axis_tdata;
	logic                     s_axis_tuser;
	logic                     s_axis_tlast;
	logic                     s_axis_tready;
	logic [axil_addr_w-1:0]   s_axil_awaddr;
	logic                     s_axil_awvalid;
	logic                     s_axil_awready;
	logic [axil_data_w-1:0]   s_axil_wdata;
	logic [axil_data_w/8-1:0] s_axil_wstrb;
	logic                     s_axil_wvalid;
	logic                     s_axil_wready;
	logic [1:0]               s_axil_bresp;
	logic                     s_axil_bvalid;
	logic                     s_axil_bready;
	logic [axil_addr_w-1:0]   s_axil_araddr;
	logic                     s_axil_arvalid;
	logic                     s_axil_arready;
	logic [axil_data_w-1:0]   s_axil_rdata;
	logic [1:0]               s_axil_rresp;
	logic                     s_axil_rvalid;
	logic                     s_axil_rready;
	logic                     frame_done;

	logic [31:0] lfsr;
	int          done_pulses = 0;
	col_rec_t    exp_rec [1 << dim_w];
	edge_res_t   exp_left;
	edge_res_t   exp_right;

	fsa_top #(.pixel_w(pixel_w)) DUT (.*);

	always #20 clk = !clk;

	always @(negedge clk) begin
		if (frame_done === 1'b1)
			done_pulses++;
	end

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("=== FAIL ===");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
			report_failure($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_rec(input string name, input col_rec_t got, input col_rec_t exp);
		if (got !== exp)
			report_failure($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_edge(input string name, input edge_res_t got, input edge_res_t exp);
		if (got !== exp)
			report_failure($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
	endtask

	// galois form with taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic take_bit(output logic b);
		b = lfsr[0];
		lfsr = lfsr_next(lfsr);
	endtask

	// idle cycle when every bit of the mask comes up set
	task automatic draw_gap(input logic [3:0] mask, output logic gap);
		logic [3:0] r;
		logic       b;
		for (int i = 0; i < 4; i++) begin
			take_bit(b);
			r[i] = b;
		end
		gap = (mask != 4'h0) && ((r & mask) == mask);
	endtask

	function automatic logic [pixel_w-1:0] pixel_value(input frame_t f, input int x, input int y);
		if (x >= f.x0 && x <= f.x1 && y >= f.y0 && y <= f.y1)
			return pixel_w'(16);
		return pixel_w'(200);
	endfunction

	task automatic model_frame(input frame_t f);
		col_rec_t rec;
		int       x;
		for (int c = 0; c < f.width; c++) begin
			rec = '0;
			for (int y = 0; y < f.height; y++) begin
				if (pixel_value(f, c, y) < pixel_w'(f.ref_level)) begin
					if (!rec.val)
						rec.top = dim_w'(y);
					rec.val = 1'b1;
					rec.bot = dim_w'(y);
				end
			end
			exp_rec[c] = rec;
		end
		exp_left  = '0;
		exp_right = '0;
		if (exp_rec[0].val) begin
			x = 0;
			while (x + 1 < f.width && exp_rec[x + 1].val)
				x++;
			exp_left = '{found: 1'b1, x: dim_w'(x)};
		end
		if (exp_rec[f.width - 1].val) begin
			x = f.width - 1;
			while (x > 0 && exp_rec[x - 1].val)
				x--;
			exp_right = '{found: 1'b1, x: dim_w'(x)};
		end
	endtask

	task automatic send_frame(input frame_t f);
		logic gap;
		for (int y = 0; y < f.height; y++) begin
			for (int x = 0; x < f.width; x++) begin
				draw_gap(f.gap_mask, gap);
				if (gap) begin
					@(posedge clk);
					#2;
					s_axis_tvalid = 1'b0;
					s_axis_tuser  = 1'b0;
					s_axis_tlast  = 1'b0;
				end
				@(posedge clk);
				#2;
				s_axis_tvalid = 1'b1;
				s_axis_tdata  = pixel_value(f, x, y);
				s_axis_tuser  = (x == 0 && y == 0);
				s_axis_tlast  = (x == f.width - 1);
				check_word("s_axis_tready", 32'(s_axis_tready), 32'h1);
			end
		end
		@(posedge clk);
		#2;
		s_axis_tvalid = 1'b0;
		s_axis_tuser  = 1'b0;
		s_axis_tlast  = 1'b0;
	endtask

	task automatic axil_write(input logic [axil_addr_w-1:0] addr, input logic [31:0] data);
		logic aw_done;
		logic w_done;
		logic aw_hs;
		logic w_hs;
		logic b_seen;
		@(posedge clk);
		#2;
		s_axil_awaddr  = addr;
		s_axil_awvalid = 1'b1;
		s_axil_wdata   = data;
		s_axil_wstrb   = '1;
		s_axil_wvalid  = 1'b1;
		aw_done = 1'b0;
		w_done  = 1'b0;
		while (!(aw_done && w_done)) begin
			@(negedge clk);
			aw_hs = s_axil_awvalid && s_axil_awready;
			w_hs  = s_axil_wvalid && s_axil_wready;
			@(posedge clk);
			#2;
			if (aw_hs) begin
				s_axil_awvalid = 1'b0;
				aw_done = 1'b1;
			end
			if (w_hs) begin
				s_axil_wvalid = 1'b0;
				w_done = 1'b1;
			end
		end
		s_axil_bready = 1'b1;
		b_seen = 1'b0;
		while (!b_seen) begin
			@(negedge clk);
			b_seen = s_axil_bvalid;
			if (b_seen)
				check_word("bresp", 32'(s_axil_bresp), 32'h0);
			@(posedge clk);
			#2;
		end
		s_axil_bready = 1'b0;
	endtask

	task automatic axil_read(input logic [axil_addr_w-1:0] addr, output logic [31:0] data);
		logic ar_hs;
		logic r_seen;
		@(posedge clk);
		#2;
		s_axil_araddr  = addr;
		s_axil_arvalid = 1'b1;
		ar_hs = 1'b0;
		while (!ar_hs) begin
			@(negedge clk);
			ar_hs = s_axil_arready;
			@(posedge clk);
			#2;
		end
		s_axil_arvalid = 1'b0;
		s_axil_rready  = 1'b1;
		r_seen = 1'b0;
		while (!r_seen) begin
			@(negedge clk);
			r_seen = s_axil_rvalid;
			data   = s_axil_rdata;
			if (r_seen)
				check_word("rresp", 32'(s_axil_rresp), 32'h0);
			@(posedge clk);
			#2;
		end
		s_axil_rready = 1'b0;
	endtask

	task automatic run_frame(input frame_t f, input int idx);
		logic [31:0] word;
		col_rec_t    rec;
		edge_res_t   res;
		axil_write(reg_height, 32'(f.height));
		axil_write(reg_width, 32'(f.width));
		axil_write(reg_ref, 32'(f.ref_level));
		axil_read(reg_width, word);
		check_word("width", word, 32'(f.width));
		model_frame(f);
		send_frame(f);
		// the read that returns 1 clears done
		word = '0;
		while (word[0] !== 1'b1)
			axil_read(reg_status, word);
		axil_read(reg_status, word);
		check_word("status after clear", word, 32'h0);
		check_word("frame_done pulses", 32'(done_pulses), 32'(idx + 1));
		axil_read(reg_left, word);
		res.found = word[31];
		res.x     = word[dim_w-1:0];
		check_edge("left", res, exp_left);
		axil_read(reg_right, word);
		res.found = word[31];
		res.x     = word[dim_w-1:0];
		check_edge("right", res, exp_right);
		for (int c = 0; c < f.width; c++) begin
			axil_write(reg_col_sel, 32'(c));
			axil_read(reg_col_rec, word);
			rec.val = word[31];
			rec.top = word[27:16];
			rec.bot = word[11:0];
			check_rec($sformatf("col_rec[%0d]", c), rec, exp_rec[c]);
		end
	endtask

	// budget grows with the pixel count of the whole table
	initial begin
		int total;
		total = 0;
		for (int i = 0; i < n_frames; i++)
			total += frames[i].width * frames[i].height;
		repeat (2 * total + 1000) @(posedge clk);
		report_failure("simulation timed out before all frames were checked");
	end

	initial begin
		resetn         = 1'b0;
		s_axis_tvalid  = 1'b0;
		s_axis_tdata   = '0;
		s_axis_tuser   = 1'b0;
		s_axis_tlast   = 1'b0;
		s_axil_awaddr  = '0;
		s_axil_awvalid = 1'b0;
		s_axil_wdata   = '0;
		s_axil_wstrb   = '0;
		s_axil_wvalid  = 1'b0;
		s_axil_bready  = 1'b0;
		s_axil_araddr  = '0;
		s_axil_arvalid = 1'b0;
		s_axil_rready  = 1'b0;
		lfsr           = 32'hc31e;
		repeat (10) @(posedge clk);
		#2;
		resetn = 1'b1;
		for (int i = 0; i < n_frames; i++)
			run_frame(frames[i], i);
		$display("=== PASS ===");
		$finish;
	end

endmodule

//--- build.f
logic/fsa_pkg.sv
logic/column_store.sv
logic/edge_scan.sv
logic/fsa_core.sv
logic/fsa_regs.sv
logic/fsa_top.sv
bench/fsa_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator, pass only if the pass line shows up
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f build.f --top-module fsa_tb -o fsa_sim \
	&& ./obj_dir/fsa_sim | tee /dev/stderr | grep -qF "=== PASS ===" \
	&& { echo "simulation passed"; exit 0; } \
	|| { echo "simulation failed"; exit 1; }
